//--- common/mem_sys_consts.svh
// widths, line geometry, bank count and memory latency of the memory system
`ifndef MEM_SYS_CONSTS_SVH
`define MEM_SYS_CONSTS_SVH

// data and byte address widths
`define DATA_W 16
`define ADDR_W 16

// address split: tag, index, word within line, byte bit
`define TAG_W 5
`define INDEX_W 8
`define WORD_SEL_W 2
`define LINE_WORDS 4

// word address into main memory
`define MEM_ADDR_W (`ADDR_W - 1)

// interleaved banks
`define BANKS 4

// cycles from command to read data or to bank free
`define MEM_LAT 4

`endif

//--- common/cache_pkg.sv
// controller state and cache-store operation types
package cache_pkg;

   // controller sequencing states
   typedef enum logic [3:0] {
      IDLE,
      COMPARE,
      WB_ISSUE,
      WB_DRAIN,
      FILL_ISSUE,
      FILL_WAIT,
      INSTALL,
      RESPOND,
      RELEASE
   } ctrl_state_e;

   // single-cycle update commands to the cache arrays
   typedef enum logic [1:0] {
      CACHE_NONE,
      CACHE_FILL_WORD,
      CACHE_INSTALL,
      CACHE_WRITE_WORD
   } cache_op_e;

endpackage

//--- common/mem_pkg.sv
// main memory command opcode type
package mem_pkg;

   // one command per cycle, the bank comes from the word address
   typedef enum logic [1:0] {
      MEM_NOP,
      MEM_RD,
      MEM_WR
   } mem_op_e;

endpackage

//--- cache/cache_store.sv
// direct-mapped cache arrays with tag lookup and single-word update
`timescale 1ns/100ps

`include "mem_sys_consts.svh"

module cache_store (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic [`INDEX_W-1:0]      index,
   input  logic [`TAG_W-1:0]        tag_in,
   input  logic [`WORD_SEL_W-1:0]   word_sel,
   input  cache_pkg::cache_op_e     op,
   input  logic [`DATA_W-1:0]       client_data,
   input  logic [`DATA_W-1:0]       fill_data,
   output logic [`DATA_W-1:0]       rdata,
   output logic                     hit,
   output logic                     valid,
   output logic                     dirty,
   output logic [`TAG_W-1:0]        tag_out
);

   localparam int LINES = 1 << `INDEX_W;
   localparam int WORDS = LINES * `LINE_WORDS;

   logic [`TAG_W-1:0]                  tag_array [LINES];
   logic [`DATA_W-1:0]                 data_array [WORDS];
   logic [LINES-1:0]                   valid_bits;
   logic [LINES-1:0]                   dirty_bits;
   logic [`INDEX_W+`WORD_SEL_W-1:0]    word_addr;

   // flat word index, line words are contiguous
   assign word_addr = {index, word_sel};

   // lookup is purely combinational
   assign tag_out = tag_array[index];
   assign valid   = valid_bits[index];
   assign dirty   = dirty_bits[index];
   assign hit     = valid && (tag_out == tag_in);
   assign rdata   = data_array[word_addr];

   // valid bits clear asynchronously, set on install
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_bits <= '0;
      end else if (op == cache_pkg::CACHE_INSTALL) begin
         valid_bits[index] <= 1'b1;
      end
   end

   // tag, dirty and data updates
   always_ff @(posedge clk) begin
      case (op)
         cache_pkg::CACHE_FILL_WORD: begin
            data_array[word_addr] <= fill_data;
         end
         cache_pkg::CACHE_INSTALL: begin
            tag_array[index]  <= tag_in;
            dirty_bits[index] <= 1'b0;
         end
         cache_pkg::CACHE_WRITE_WORD: begin
            data_array[word_addr] <= client_data;
            dirty_bits[index]     <= 1'b1;
         end
         default: begin
         end
      endcase
   end

   // the controller may only write into a resident line
   a_write_hits_line: assert property (
      @(posedge clk) disable iff (!arst_n)
      op == cache_pkg::CACHE_WRITE_WORD |-> hit
   );

endmodule

//--- mem/banked_mem.sv
// four-bank interleaved word memory with fixed latency and per-bank busy flags
`timescale 1ns/100ps

`include "mem_sys_consts.svh"

module banked_mem (
   input  logic                     clk,
   input  logic                     arst_n,
   input  mem_pkg::mem_op_e         cmd,
   input  logic [`MEM_ADDR_W-1:0]   mem_addr,
   input  logic [`DATA_W-1:0]       mem_wdata,
   output logic [`DATA_W-1:0]       rd_data,
   output logic                     rdata_valid,
   output logic [`BANKS-1:0]        busy
);

   localparam int MEM_WORDS = 1 << `MEM_ADDR_W;
   localparam int BANK_W    = $clog2(`BANKS);
   localparam int CNT_W     = $clog2(`MEM_LAT + 1);

   logic [`DATA_W-1:0]  mem_array [MEM_WORDS];
   logic [CNT_W-1:0]    bank_cnt [`BANKS];
   logic [`DATA_W-1:0]  rd_pipe [`MEM_LAT];
   logic [`MEM_LAT-1:0] vld_pipe;
   logic [BANK_W-1:0]   bank_sel;

   // low word address bits pick the bank
   assign bank_sel = mem_addr[BANK_W-1:0];

   // contents start at zero, never reset afterwards
   initial begin
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem_array[i] = '0;
      end
   end

   // writes land in the issue cycle
   always @(posedge clk) begin
      if (cmd == mem_pkg::MEM_WR) begin
         mem_array[mem_addr] <= mem_wdata;
      end
   end

   // busy countdown per bank
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int b = 0; b < `BANKS; b++) begin
            bank_cnt[b] <= '0;
         end
      end else begin
         for (int b = 0; b < `BANKS; b++) begin
            if (cmd != mem_pkg::MEM_NOP && bank_sel == BANK_W'(b)) begin
               bank_cnt[b] <= CNT_W'(`MEM_LAT);
            end else if (bank_cnt[b] != '0) begin
               bank_cnt[b] <= bank_cnt[b] - 1'b1;
            end
         end
      end
   end

   always_comb begin
      for (int b = 0; b < `BANKS; b++) begin
         busy[b] = (bank_cnt[b] != '0);
      end
   end

   // read data travels down a fixed-length pipe
   always_ff @(posedge clk) begin
      rd_pipe[0] <= mem_array[mem_addr];
      for (int s = 1; s < `MEM_LAT; s++) begin
         rd_pipe[s] <= rd_pipe[s-1];
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         vld_pipe <= '0;
      end else begin
         vld_pipe <= {vld_pipe[`MEM_LAT-2:0], cmd == mem_pkg::MEM_RD};
      end
   end

   assign rd_data     = rd_pipe[`MEM_LAT-1];
   assign rdata_valid = vld_pipe[`MEM_LAT-1];

   // the controller must respect bank occupancy
   a_no_busy_cmd: assert property (
      @(posedge clk) disable iff (!arst_n)
      cmd != mem_pkg::MEM_NOP |-> !busy[bank_sel]
   );

endmodule

//--- hw/cache_ctrl.sv
// cache controller FSM for lookup, write-back, fill, install and client handshake
`timescale 1ns/100ps

`include "mem_sys_consts.svh"

module cache_ctrl (
   input  logic                     clk,
   input  logic                     arst_n,
   // client side
   input  logic                     req,
   input  logic                     rd,
   input  logic                     wr,
   input  logic [`ADDR_W-1:0]       addr,
   input  logic [`DATA_W-1:0]       wdata,
   output logic                     ack,
   output logic [`DATA_W-1:0]       rdata,
   output logic                     hit_out,
   output logic                     err,
   // cache store side
   output logic [`INDEX_W-1:0]      index,
   output logic [`TAG_W-1:0]        tag_sel,
   output logic [`WORD_SEL_W-1:0]   word_sel,
   output cache_pkg::cache_op_e     op,
   output logic [`DATA_W-1:0]       fill_data,
   input  logic                     hit,
   input  logic                     valid,
   input  logic                     dirty,
   input  logic [`TAG_W-1:0]        tag_out,
   input  logic [`DATA_W-1:0]       cache_rdata,
   // memory side
   output mem_pkg::mem_op_e         cmd,
   output logic [`MEM_ADDR_W-1:0]   mem_addr,
   output logic [`DATA_W-1:0]       mem_wdata,
   input  logic [`DATA_W-1:0]       rd_data,
   input  logic                     rdata_valid,
   input  logic [`BANKS-1:0]        busy
);

   cache_pkg::ctrl_state_e    state;
   cache_pkg::ctrl_state_e    next_state;

   logic                      rd_q;
   logic                      wr_q;
   logic [`ADDR_W-1:0]        addr_q;
   logic [`DATA_W-1:0]        wdata_q;
   logic [`WORD_SEL_W-1:0]    req_word;
   logic [`WORD_SEL_W-1:0]    issue_cnt;
   logic [`WORD_SEL_W-1:0]    ret_cnt;
   logic                      inst_phase;
   logic [2:0]                rd_inflight;
   logic                      err_cond;
   logic                      issue_ok;
   logic                      last_ret;

   // address fields of the latched request
   assign tag_sel  = addr_q[`ADDR_W-1 -: `TAG_W];
   assign index    = addr_q[`WORD_SEL_W+1 +: `INDEX_W];
   assign req_word = addr_q[1 +: `WORD_SEL_W];

   // both strobes or an odd byte address
   assign err_cond = (rd_q & wr_q) | addr_q[0];

   // line word n lives in bank n
   assign issue_ok = !busy[issue_cnt];
   assign last_ret = rdata_valid && (ret_cnt == '1);

   // memory returns go straight into the line, victim words straight out
   assign fill_data = rd_data;
   assign mem_wdata = cache_rdata;

   always_comb begin
      next_state = state;
      op         = cache_pkg::CACHE_NONE;
      cmd        = mem_pkg::MEM_NOP;
      mem_addr   = {tag_sel, index, issue_cnt};
      word_sel   = req_word;
      case (state)
         cache_pkg::IDLE: begin
            if (req) begin
               next_state = cache_pkg::COMPARE;
            end
         end
         cache_pkg::COMPARE: begin
            if (err_cond) begin
               next_state = cache_pkg::RESPOND;
            end else if (hit) begin
               if (wr_q) begin
                  op = cache_pkg::CACHE_WRITE_WORD;
               end
               next_state = cache_pkg::RESPOND;
            end else if (valid && dirty) begin
               next_state = cache_pkg::WB_ISSUE;
            end else begin
               next_state = cache_pkg::FILL_ISSUE;
            end
         end
         cache_pkg::WB_ISSUE: begin
            // victim address comes from the stored tag
            word_sel = issue_cnt;
            mem_addr = {tag_out, index, issue_cnt};
            if (issue_ok) begin
               cmd = mem_pkg::MEM_WR;
               if (issue_cnt == '1) begin
                  next_state = cache_pkg::WB_DRAIN;
               end
            end
         end
         cache_pkg::WB_DRAIN: begin
            if (busy == '0) begin
               next_state = cache_pkg::FILL_ISSUE;
            end
         end
         cache_pkg::FILL_ISSUE: begin
            // early returns possible if a bank held up an issue
            word_sel = ret_cnt;
            if (rdata_valid) begin
               op = cache_pkg::CACHE_FILL_WORD;
            end
            if (issue_ok) begin
               cmd = mem_pkg::MEM_RD;
               if (issue_cnt == '1) begin
                  next_state = cache_pkg::FILL_WAIT;
               end
            end
         end
         cache_pkg::FILL_WAIT: begin
            word_sel = ret_cnt;
            if (rdata_valid) begin
               op = cache_pkg::CACHE_FILL_WORD;
            end
            if (last_ret) begin
               next_state = cache_pkg::INSTALL;
            end
         end
         cache_pkg::INSTALL: begin
            // a write miss takes a second cycle for the client word
            if (inst_phase) begin
               op         = cache_pkg::CACHE_WRITE_WORD;
               next_state = cache_pkg::RESPOND;
            end else begin
               op = cache_pkg::CACHE_INSTALL;
               if (!wr_q) begin
                  next_state = cache_pkg::RESPOND;
               end
            end
         end
         cache_pkg::RESPOND: begin
            if (!req) begin
               next_state = cache_pkg::RELEASE;
            end
         end
         cache_pkg::RELEASE: begin
            next_state = cache_pkg::IDLE;
         end
         default: begin
            next_state = cache_pkg::IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state       <= cache_pkg::IDLE;
         ack         <= 1'b0;
         hit_out     <= 1'b0;
         err         <= 1'b0;
         issue_cnt   <= '0;
         ret_cnt     <= '0;
         inst_phase  <= 1'b0;
         rd_inflight <= '0;
      end else begin
         state <= next_state;
         ack   <= (next_state == cache_pkg::RESPOND);
         // both counters wrap after four words
         if (cmd != mem_pkg::MEM_NOP) begin
            issue_cnt <= issue_cnt + 1'b1;
         end
         if (rdata_valid) begin
            ret_cnt <= ret_cnt + 1'b1;
         end
         case ({cmd == mem_pkg::MEM_RD, rdata_valid})
            2'b10:   rd_inflight <= rd_inflight + 1'b1;
            2'b01:   rd_inflight <= rd_inflight - 1'b1;
            default: rd_inflight <= rd_inflight;
         endcase
         if (state == cache_pkg::INSTALL) begin
            inst_phase <= !inst_phase && wr_q;
         end
         if (state == cache_pkg::COMPARE) begin
            hit_out <= hit && !err_cond;
            err     <= err_cond;
         end
      end
   end

   // request latch and response data
   always_ff @(posedge clk) begin
      if (state == cache_pkg::IDLE && req) begin
         rd_q    <= rd;
         wr_q    <= wr;
         addr_q  <= addr;
         wdata_q <= wdata;
      end
      if (state == cache_pkg::COMPARE) begin
         if (err_cond) begin
            rdata <= '0;
         end else if (wr_q) begin
            rdata <= wdata_q;
         end else begin
            rdata <= cache_rdata;
         end
      end
      if (state == cache_pkg::INSTALL && next_state == cache_pkg::RESPOND) begin
         rdata <= wr_q ? wdata_q : cache_rdata;
      end
   end

   // ack and the response stay put until the client lets go of req
   a_ack_held: assert property (
      @(posedge clk) disable iff (!arst_n)
      ack && req |=> ack && $stable(rdata) && $stable(hit_out) && $stable(err)
   );

   // one read per bank at most
   a_reads_in_flight: assert property (
      @(posedge clk) disable iff (!arst_n)
      rd_inflight <= 3'd4
   );

endmodule

//--- hw/mem_system.sv
// memory system top with cache controller, cache arrays and banked main memory
`timescale 1ns/100ps

`include "mem_sys_consts.svh"

module mem_system (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  req,
   input  logic                  rd,
   input  logic                  wr,
   input  logic [`ADDR_W-1:0]    addr,
   input  logic [`DATA_W-1:0]    wdata,
   output logic                  ack,
   output logic [`DATA_W-1:0]    rdata,
   output logic                  hit,
   output logic                  err
);

   // controller to cache store
   logic [`INDEX_W-1:0]       index;
   logic [`TAG_W-1:0]         tag_sel;
   logic [`WORD_SEL_W-1:0]    word_sel;
   cache_pkg::cache_op_e      op;
   logic [`DATA_W-1:0]        fill_data;
   logic                      cache_hit;
   logic                      valid;
   logic                      dirty;
   logic [`TAG_W-1:0]         tag_out;
   logic [`DATA_W-1:0]        cache_rdata;

   // controller to main memory
   mem_pkg::mem_op_e          cmd;
   logic [`MEM_ADDR_W-1:0]    mem_addr;
   logic [`DATA_W-1:0]        mem_wdata;
   logic [`DATA_W-1:0]        rd_data;
   logic                      rdata_valid;
   logic [`BANKS-1:0]         busy;

   cache_ctrl u_ctrl (
      .clk         (clk),
      .arst_n      (arst_n),
      .req         (req),
      .rd          (rd),
      .wr          (wr),
      .addr        (addr),
      .wdata       (wdata),
      .ack         (ack),
      .rdata       (rdata),
      .hit_out     (hit),
      .err         (err),
      .index       (index),
      .tag_sel     (tag_sel),
      .word_sel    (word_sel),
      .op          (op),
      .fill_data   (fill_data),
      .hit         (cache_hit),
      .valid       (valid),
      .dirty       (dirty),
      .tag_out     (tag_out),
      .cache_rdata (cache_rdata),
      .cmd         (cmd),
      .mem_addr    (mem_addr),
      .mem_wdata   (mem_wdata),
      .rd_data     (rd_data),
      .rdata_valid (rdata_valid),
      .busy        (busy)
   );

   // client word is held stable for the whole request
   cache_store u_store (
      .clk         (clk),
      .arst_n      (arst_n),
      .index       (index),
      .tag_in      (tag_sel),
      .word_sel    (word_sel),
      .op          (op),
      .client_data (wdata),
      .fill_data   (fill_data),
      .rdata       (cache_rdata),
      .hit         (cache_hit),
      .valid       (valid),
      .dirty       (dirty),
      .tag_out     (tag_out)
   );

   banked_mem u_mem (
      .clk         (clk),
      .arst_n      (arst_n),
      .cmd         (cmd),
      .mem_addr    (mem_addr),
      .mem_wdata   (mem_wdata),
      .rd_data     (rd_data),
      .rdata_valid (rdata_valid),
      .busy        (busy)
   );

endmodule

//--- tb/mem_system_tb.sv
// testbench for the cached memory system with a reference model, random mix and watchdog
`timescale 1ns/100ps

`include "mem_sys_consts.svh"

module mem_system_tb;

   localparam int CLK_HALF   = 20;
   localparam int NUM_RAND   = 400;
   localparam int NUM_DIRECT = 16;
   localparam int MISS_BOUND = 40;
   localparam int HIT_CYCLES = 3;
   localparam int LINES      = 1 << `INDEX_W;
   localparam int MEM_WORDS  = 1 << (`ADDR_W - 1);
   // worst-case miss per transaction plus some slack for reset
   localparam int TIMEOUT_NS = ((NUM_RAND + NUM_DIRECT) * MISS_BOUND + 100) * 2 * CLK_HALF;

   logic                clk;
   logic                arst_n;
   logic                req;
   logic                rd;
   logic                wr;
   logic [`ADDR_W-1:0]  addr;
   logic [`DATA_W-1:0]  wdata;
   logic                ack;
   logic [`DATA_W-1:0]  rdata;
   logic                hit;
   logic                err;

   // coherent memory image and direct-mapped tag mirror
   logic [`DATA_W-1:0]  ref_mem [MEM_WORDS];
   logic [`TAG_W-1:0]   ref_tag [LINES];
   logic                ref_valid [LINES];

   integer              seed;
   int                  errors;
   int                  checks;

   mem_system dut (
      .clk    (clk),
      .arst_n (arst_n),
      .req    (req),
      .rd     (rd),
      .wr     (wr),
      .addr   (addr),
      .wdata  (wdata),
      .ack    (ack),
      .rdata  (rdata),
      .hit    (hit),
      .err    (err)
   );

   always #CLK_HALF clk = ~clk;

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      assert (actual === expected) else begin
         $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
         errors++;
      end
   endtask

   task automatic check_true(input string what, input logic cond);
      checks++;
      assert (cond === 1'b1) else begin
         $display("ERROR: %s", what);
         errors++;
      end
   endtask

   // one full four-phase handshake, expectations come from the model
   task automatic run_access(input string name, input logic do_rd, input logic do_wr,
                             input logic [`ADDR_W-1:0] a, input logic [`DATA_W-1:0] d,
                             input int hold);
      logic                bad;
      logic                exp_hit;
      logic [`DATA_W-1:0]  exp_data;
      logic [`ADDR_W-2:0]  widx;
      logic [`INDEX_W-1:0] idx;
      logic [`TAG_W-1:0]   t;
      logic [`DATA_W-1:0]  got_data;
      logic                got_hit;
      logic                got_err;
      int                  cycles;

      bad      = (do_rd && do_wr) || a[0];
      widx     = a[`ADDR_W-1:1];
      t        = a[`ADDR_W-1:`ADDR_W-`TAG_W];
      idx      = a[`INDEX_W+`WORD_SEL_W:`WORD_SEL_W+1];
      exp_hit  = 1'b0;
      exp_data = '0;
      if (!bad) begin
         exp_hit = ref_valid[idx] && (ref_tag[idx] == t);
         if (do_wr) begin
            ref_mem[widx] = d;
         end
         exp_data       = ref_mem[widx];
         ref_valid[idx] = 1'b1;
         ref_tag[idx]   = t;
      end

      @(posedge clk);
      req   <= 1'b1;
      rd    <= do_rd;
      wr    <= do_wr;
      addr  <= a;
      wdata <= d;

      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
      end while (!ack);

      got_data = rdata;
      got_hit  = hit;
      got_err  = err;
      check_value($sformatf("%s err", name), 32'(bad), 32'(got_err));
      check_value($sformatf("%s hit", name), 32'(exp_hit), 32'(got_hit));
      if (!bad) begin
         check_value($sformatf("%s rdata", name), 32'(exp_data), 32'(got_data));
      end
      // hits and errors take the short path
      if (bad || exp_hit) begin
         check_value($sformatf("%s ack latency", name), HIT_CYCLES, cycles);
      end

      // outputs frozen while the client holds req
      for (int i = 0; i < hold; i++) begin
         @(negedge clk);
         check_true($sformatf("%s: ack dropped while req was still high", name), ack);
         check_value($sformatf("%s held rdata", name), 32'(got_data), 32'(rdata));
         check_value($sformatf("%s held hit", name), 32'(got_hit), 32'(hit));
         check_value($sformatf("%s held err", name), 32'(got_err), 32'(err));
      end

      @(posedge clk);
      req <= 1'b0;
      do begin
         @(negedge clk);
      end while (ack);
   endtask

   task automatic run_random_mix(input int count);
      logic [31:0]          r;
      logic [`TAG_W-1:0]    t;
      logic [`INDEX_W-1:0]  idx;
      logic [`ADDR_W-1:0]   a;
      int                   hold;

      for (int n = 0; n < count; n++) begin
         r    = $random(seed);
         // few tags over few lines, so conflicts are frequent
         t    = 5'(r[1:0]) + 5'd8;
         idx  = 8'(r[3:2]) + 8'd64;
         a    = {t, idx, r[5:4], 1'b0};
         hold = int'(r[12:11]);
         if (r[9:6] == 4'd0) begin
            if (r[10]) begin
               run_access("random odd address", 1'b1, 1'b0, a | 16'h0001, r[31:16], hold);
            end else begin
               run_access("random rd and wr", 1'b1, 1'b1, a, r[31:16], hold);
            end
         end else if (r[9]) begin
            run_access("random write", 1'b0, 1'b1, a, r[31:16], hold);
         end else begin
            run_access("random read", 1'b1, 1'b0, a, r[31:16], hold);
         end
      end
   endtask

   // watchdog
   initial begin
      #(TIMEOUT_NS);
      $display("timeout: ack never arrived or never dropped within %0d ns", TIMEOUT_NS);
      $display("Simulation failed");
      $finish;
   end

   initial begin
      clk    = 1'b0;
      arst_n = 1'b0;
      req    = 1'b0;
      rd     = 1'b0;
      wr     = 1'b0;
      addr   = '0;
      wdata  = '0;
      seed   = 32'h9fe6eda4;
      errors = 0;
      checks = 0;
      for (int i = 0; i < MEM_WORDS; i++) begin
         ref_mem[i] = '0;
      end
      for (int i = 0; i < LINES; i++) begin
         ref_valid[i] = 1'b0;
         ref_tag[i]   = '0;
      end

      repeat (3) @(posedge clk);
      arst_n <= 1'b1;

      // untouched word reads as zero, then hits
      run_access("read miss", 1'b1, 1'b0, {5'd3, 8'd10, 2'd1, 1'b0}, 16'h0, 0);
      run_access("read hit", 1'b1, 1'b0, {5'd3, 8'd10, 2'd1, 1'b0}, 16'h0, 0);

      // write then read back
      run_access("write miss", 1'b0, 1'b1, {5'd7, 8'd33, 2'd2, 1'b0}, 16'hbeef, 1);
      run_access("read after write", 1'b1, 1'b0, {5'd7, 8'd33, 2'd2, 1'b0}, 16'h0, 0);

      // dirty victim must reach memory before the conflicting fill
      run_access("dirty write", 1'b0, 1'b1, {5'd1, 8'd20, 2'd3, 1'b0}, 16'h1234, 0);
      run_access("conflict read", 1'b1, 1'b0, {5'd6, 8'd20, 2'd0, 1'b0}, 16'h0, 0);
      run_access("evicted reread", 1'b1, 1'b0, {5'd1, 8'd20, 2'd3, 1'b0}, 16'h0, 0);

      // rejected requests leave no trace
      run_access("odd address", 1'b1, 1'b0, {5'd7, 8'd33, 2'd2, 1'b1}, 16'h0, 0);
      run_access("rd and wr", 1'b1, 1'b1, {5'd7, 8'd33, 2'd2, 1'b0}, 16'haaaa, 0);
      run_access("after errors", 1'b1, 1'b0, {5'd7, 8'd33, 2'd2, 1'b0}, 16'h0, 0);

      // long hold after ack on a hit and on a miss
      run_access("held hit", 1'b0, 1'b1, {5'd7, 8'd33, 2'd0, 1'b0}, 16'h5a5a, 3);
      run_access("held miss", 1'b1, 1'b0, {5'd9, 8'd33, 2'd0, 1'b0}, 16'h0, 3);

      run_random_mix(NUM_RAND);

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

//--- flist.f
+incdir+common
common/cache_pkg.sv
common/mem_pkg.sv
cache/cache_store.sv
mem/banked_mem.sv
hw/cache_ctrl.sv
hw/mem_system.sv
tb/mem_system_tb.sv

//--- Makefile
# Verilator build and run for the cached memory system
# every variable can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= mem_system_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
PASS_MSG  ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
